// ==== all.f ====
avionics_pkg.sv
us_tick_gen.sv
radio_capture.sv
board_control.sv
esc_driver.sv
avionics_top.sv
tb_avionics.sv

// ==== tb_avionics.sv ====
/*
  Directed testbench for avionics_top, assuming a 10 MHz clock.
  Radio frames repeat every 5000 us; ESC high times are measured in clk cycles.
*/
`timescale 1ns/1ps

module tb_avionics import avionics_pkg::*; ();

  localparam int RADIO_FRAME_CYC = 5000 * TICK_DIV;
  localparam int MAX_CYCLES      = 3_000_000;

  logic            clk = 1'b0;
  logic            rst;
  logic [N_CH-1:0] radio_sig;
  logic            shutdown_req;
  logic [N_CH-1:0] esc_sig;
  logic [N_CH-1:0] led;
  board_state_t    board_state;
  logic            armed;

  // Commanded and latched radio widths, plus the last width the DUT should accept
  int cmd_w [N_CH];
  bit cmd_en [N_CH];
  int lat_w [N_CH];
  bit lat_en [N_CH];
  int acc_w [N_CH];
  bit arm_exp;
  int frame_cyc = 0;
  int radio_frames = 0;
  int hi_cnt [N_CH];
  int meas [N_CH];
  int fall_cyc [N_CH];
  int esc_starts = 0;
  logic [N_CH-1:0] esc_prev = '0;
  logic [N_CH-1:0] radio_prev = '0;
  int cycles = 0;
  int passes = 0;
  int fails = 0;
  int err_mark = 0;

  avionics_top u_dut (
    .clk          (clk),
    .rst          (rst),
    .radio_sig    (radio_sig),
    .shutdown_req (shutdown_req),
    .esc_sig      (esc_sig),
    .led          (led),
    .board_state  (board_state),
    .armed        (armed)
  );

  always #50 clk = ~clk;

  // Radio pulse generator, widths latched per frame so a pulse is never cut
  always @(posedge clk) begin
    if (frame_cyc == 0) begin
      lat_w = cmd_w;
      lat_en = cmd_en;
      radio_frames++;
    end
    for (int i = 0; i < N_CH; i++) begin
      radio_sig[i] <= lat_en[i] && (frame_cyc < lat_w[i] * TICK_DIV);
    end
    frame_cyc = (frame_cyc == RADIO_FRAME_CYC - 1) ? 0 : frame_cyc + 1;
  end

  // ESC high time monitor, samples the value held over the previous cycle
  always @(posedge clk) begin
    for (int i = 0; i < N_CH; i++) begin
      if (esc_sig[i]) begin
        hi_cnt[i]++;
      end else if (esc_prev[i]) begin
        meas[i] = hi_cnt[i];
        hi_cnt[i] = 0;
      end
      // Last falling edge of each radio line
      if (radio_prev[i] && !radio_sig[i]) begin
        fall_cyc[i] = cycles;
      end
    end
    if (esc_sig[0] && !esc_prev[0]) esc_starts++;
    esc_prev = esc_sig;
    radio_prev = radio_sig;
    cycles++;
  end

  initial begin
    while (cycles < MAX_CYCLES) @(posedge clk);
    $display("Timeout: tests did not complete within %0d clock cycles", MAX_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  task automatic check(input string name, input int exp, input int act);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
      fails++;
    end else begin
      passes++;
    end
  endtask

  function automatic int esc_expect(input int ch);
    if (!arm_exp) return ESC_MIN_US;
    if (acc_w[ch] < ESC_MIN_US) return ESC_MIN_US;
    if (acc_w[ch] > ESC_MAX_US) return ESC_MAX_US;
    return acc_w[ch];
  endfunction

  task automatic check_escs();
    for (int i = 0; i < N_CH; i++) begin
      check($sformatf("esc_sig[%0d] width", i), esc_expect(i), meas[i] / TICK_DIV);
    end
  endtask

  task automatic set_width(input int ch, input int w);
    cmd_w[ch] = w;
    if (w >= PULSE_MIN_US && w <= PULSE_MAX_US) acc_w[ch] = w;
  endtask

  task automatic wait_radio(input int n);
    int target;
    target = radio_frames + n;
    while (radio_frames < target) @(negedge clk);
  endtask

  // Second frame start after the call means a fully post-change frame ended
  task automatic wait_esc(input int n);
    int target;
    target = esc_starts + n;
    while (esc_starts < target) @(negedge clk);
  endtask

  task automatic wait_state(input board_state_t s);
    do @(negedge clk); while (board_state != s);
  endtask

  task automatic test_done(input string name);
    $display("%s: %s (%0d errors)", name, (fails == err_mark) ? "passed" : "failed",
             fails - err_mark);
    err_mark = fails;
  endtask

  task automatic test_startup_hold();
    wait_esc(3);
    check("board_state", BOARD_STARTUP, board_state);
    check("armed", 0, armed);
    check("led", 0, led);
    check_escs();
    test_done("startup_hold");
  endtask

  task automatic test_link_up();
    for (int i = 0; i < N_CH; i++) begin
      set_width(i, (i == ARM_CH) ? 1000 : $urandom_range(PULSE_MAX_US, PULSE_MIN_US));
      cmd_en[i] = 1'b1;
    end
    wait_state(BOARD_RUNNING);
    wait_esc(2);
    check("led", 8'hff, led);
    check("armed", 0, armed);
    check_escs();
    test_done("link_up");
  endtask

  task automatic test_arm_pass_through();
    for (int i = 0; i < N_CH; i++) set_width(i, 1000 + 120 * i);
    set_width(0, 900);
    set_width(1, 2100);
    set_width(ARM_CH, 1900);
    wait_radio(2);
    arm_exp = 1'b1;
    check("armed", 1, armed);
    wait_esc(2);
    check_escs();
    set_width(ARM_CH, 1000);
    wait_radio(2);
    set_width(ARM_CH, 1900);
    wait_radio(2);
    arm_exp = 1'b0;
    check("armed", 0, armed);
    wait_esc(2);
    check_escs();
    test_done("arm_pass_through");
  endtask

  task automatic test_range_reject();
    set_width(ARM_CH, 1000);
    wait_radio(2);
    set_width(ARM_CH, 1900);
    wait_radio(2);
    arm_exp = 1'b1;
    check("armed", 1, armed);
    set_width(2, 2500);
    wait_radio(2);
    wait_esc(2);
    check_escs();
    // Back in range before channel 2 ages out
    set_width(2, acc_w[2]);
    wait_radio(2);
    test_done("range_reject");
  endtask

  task automatic test_signal_loss();
    int delay;
    cmd_en[3] = 1'b0;
    while (led[3] !== 1'b0) @(negedge clk);
    // Counted from the last accepted pulse on channel 3
    delay = cycles - fall_cyc[3];
    check("led[3] loss delay in window", 1,
          delay >= (LOSS_US - 1) * TICK_DIV && delay <= (LOSS_US + 1) * TICK_DIV);
    repeat (2) @(negedge clk);
    arm_exp = 1'b0;
    check("armed", 0, armed);
    check("led", 8'hf7, led);
    wait_esc(2);
    check_escs();
    cmd_en[3] = 1'b1;
    wait_radio(2);
    check("led", 8'hff, led);
    check("armed", 0, armed);
    wait_esc(2);
    check_escs();
    test_done("signal_loss");
  endtask

  task automatic test_shutdown();
    // Armed going in, so the shutdown has something to clear
    set_width(ARM_CH, 1000);
    wait_radio(2);
    set_width(ARM_CH, 1900);
    wait_radio(2);
    check("armed", 1, armed);
    @(posedge clk);
    shutdown_req <= 1'b1;
    wait_state(BOARD_SHUTDOWN);
    arm_exp = 1'b0;
    @(negedge clk);
    check("board_state", BOARD_IDLE, board_state);
    @(negedge clk);
    check("board_state", BOARD_STARTUP, board_state);
    @(negedge clk);
    check("board_state", BOARD_RUNNING, board_state);
    check("armed", 0, armed);
    @(posedge clk);
    shutdown_req <= 1'b0;
    wait_esc(2);
    check_escs();
    test_done("shutdown");
  endtask

  initial begin
    rst = 1'b1;
    shutdown_req = 1'b0;
    radio_sig = '0;
    arm_exp = 1'b0;
    void'($urandom(75437));
    for (int i = 0; i < N_CH; i++) begin
      cmd_w[i] = 1000;
      cmd_en[i] = 1'b0;
      acc_w[i] = 0;
      hi_cnt[i] = 0;
      meas[i] = 0;
      fall_cyc[i] = 0;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    test_startup_hold();
    test_link_up();
    test_arm_pass_through();
    test_range_reject();
    test_signal_loss();
    test_shutdown();
    $display("Checks passed: %0d, failed: %0d", passes, fails);
    if (fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== avionics_top.sv ====
/*
  Flight-board top: radio capture, board sequence and ESC outputs.
  ESC outputs follow the radio directly, with no mixing.
*/
`timescale 1ns/1ps

module avionics_top import avionics_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic [N_CH-1:0] radio_sig,
  input  logic            shutdown_req,
  output logic [N_CH-1:0] esc_sig,
  output logic [N_CH-1:0] led,
  output board_state_t    board_state,
  output logic            armed
);

  logic                tick;
  rc_chan_t [N_CH-1:0] chan;

  us_tick_gen u_tick_gen (
    .clk  (clk),
    .rst  (rst),
    .tick (tick)
  );

  // One capture block per receiver channel
  for (genvar i = 0; i < N_CH; i++) begin : g_capture
    radio_capture u_capture (
      .clk      (clk),
      .rst      (rst),
      .tick     (tick),
      .radio_in (radio_sig[i]),
      .chan     (chan[i])
    );

    // LED shows link status per channel
    assign led[i] = chan[i].live;
  end

  board_control u_board_control (
    .clk          (clk),
    .rst          (rst),
    .chan         (chan),
    .shutdown_req (shutdown_req),
    .board_state  (board_state),
    .armed        (armed)
  );

  esc_driver u_esc_driver (
    .clk     (clk),
    .rst     (rst),
    .tick    (tick),
    .armed   (armed),
    .chan    (chan),
    .esc_sig (esc_sig)
  );

endmodule

// ==== esc_driver.sv ====
/*
  ESC pulse generator, one frame every ESC_FRAME_US ticks.
  Widths are latched at frame start, so input changes show up next frame.
  Disarmed outputs carry ESC_MIN_US.
*/
`timescale 1ns/1ps

module esc_driver import avionics_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                tick,
  input  logic                armed,
  input  rc_chan_t [N_CH-1:0] chan,
  output logic [N_CH-1:0]     esc_sig
);

  logic [FRAME_BITS-1:0]            frame_cnt;
  logic                             frame_start;
  logic [N_CH-1:0][WIDTH_BITS-1:0]  target;
  logic [N_CH-1:0][WIDTH_BITS-1:0]  remain;

  // Frame timer in ticks
  always_ff @(posedge clk) begin
    if (rst) begin
      frame_cnt <= '0;
    end else if (tick) begin
      if (frame_cnt == FRAME_BITS'(ESC_FRAME_US - 1)) begin
        frame_cnt <= '0;
      end else begin
        frame_cnt <= frame_cnt + 1'b1;
      end
    end
  end

  assign frame_start = tick && (frame_cnt == '0);

  // Clamp each channel to the ESC range, or idle when disarmed
  always_comb begin
    for (int i = 0; i < N_CH; i++) begin
      if (!armed) begin
        target[i] = WIDTH_BITS'(ESC_MIN_US);
      end else if (chan[i].width_us < WIDTH_BITS'(ESC_MIN_US)) begin
        target[i] = WIDTH_BITS'(ESC_MIN_US);
      end else if (chan[i].width_us > WIDTH_BITS'(ESC_MAX_US)) begin
        target[i] = WIDTH_BITS'(ESC_MAX_US);
      end else begin
        target[i] = chan[i].width_us;
      end
    end
  end

  // High from frame start until the latched count of ticks has passed
  always_ff @(posedge clk) begin
    if (rst) begin
      esc_sig <= '0;
      remain  <= '0;
    end else begin
      for (int i = 0; i < N_CH; i++) begin
        if (frame_start) begin
          esc_sig[i] <= 1'b1;
          remain[i]  <= target[i];
        end else if (tick && esc_sig[i]) begin
          remain[i] <= remain[i] - 1'b1;
          if (remain[i] == WIDTH_BITS'(1)) begin
            esc_sig[i] <= 1'b0;
          end
        end
      end
    end
  end

endmodule

// ==== board_control.sv ====
/*
  Board sequence idle, startup, running, shutdown, plus motor arm toggle.
  Startup waits for every radio channel to be live. Arming is dropped
  whenever the board is not running or any channel is lost.
*/
`timescale 1ns/1ps

module board_control import avionics_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  rc_chan_t [N_CH-1:0]     chan,
  input  logic                    shutdown_req,
  output board_state_t            board_state,
  output logic                    armed
);

  board_state_t state_next;
  logic         shut_sync_1;
  logic         shut_sync_2;
  logic         shut_prev;
  logic         shut_rise;
  logic [N_CH-1:0] live_bits;
  logic         all_live;
  logic         arm_high;
  logic         arm_prev;

  always_comb begin
    for (int i = 0; i < N_CH; i++) begin
      live_bits[i] = chan[i].live;
    end
  end

  assign all_live = &live_bits;
  assign arm_high = chan[ARM_CH].width_us > WIDTH_BITS'(ARM_THRESH_US);

  // Shutdown request comes from outside the clock domain
  always_ff @(posedge clk) begin
    if (rst) begin
      shut_sync_1 <= 1'b0;
      shut_sync_2 <= 1'b0;
      shut_prev   <= 1'b0;
    end else begin
      shut_sync_1 <= shutdown_req;
      shut_sync_2 <= shut_sync_1;
      shut_prev   <= shut_sync_2;
    end
  end

  assign shut_rise = shut_sync_2 & ~shut_prev;

  always_comb begin
    state_next = board_state;
    case (board_state)
      BOARD_IDLE:     state_next = BOARD_STARTUP;
      BOARD_STARTUP:  if (all_live) state_next = BOARD_RUNNING;
      BOARD_RUNNING:  if (shut_rise) state_next = BOARD_SHUTDOWN;
      BOARD_SHUTDOWN: state_next = BOARD_IDLE;
      default:        state_next = BOARD_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      board_state <= BOARD_IDLE;
    end else begin
      board_state <= state_next;
    end
  end

  // Arm switch edge tracks always, so a held switch never re-arms on link return
  always_ff @(posedge clk) begin
    if (rst) begin
      arm_prev <= 1'b0;
      armed    <= 1'b0;
    end else begin
      arm_prev <= arm_high;
      if (board_state != BOARD_RUNNING || !all_live) begin
        armed <= 1'b0;
      end else if (arm_high && !arm_prev) begin
        armed <= ~armed;
      end
    end
  end

endmodule

// ==== radio_capture.sv ====
/*
  Servo pulse capture for one receiver line, measured in whole ticks.
  Pulses outside PULSE_MIN_US..PULSE_MAX_US are dropped; live falls after
  LOSS_US ticks without an accepted pulse. Width is kept after loss.
*/
`timescale 1ns/1ps

module radio_capture import avionics_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     tick,
  input  logic     radio_in,
  output rc_chan_t chan
);

  logic                  sync_1;
  logic                  sync_2;
  logic                  sync_prev;
  logic                  rise;
  logic                  fall;
  logic [WIDTH_BITS-1:0] high_cnt;
  logic                  in_range;
  logic [LOSS_BITS-1:0]  age_cnt;

  // Two-flop synchronizer plus edge register
  always_ff @(posedge clk) begin
    if (rst) begin
      sync_1    <= 1'b0;
      sync_2    <= 1'b0;
      sync_prev <= 1'b0;
    end else begin
      sync_1    <= radio_in;
      sync_2    <= sync_1;
      sync_prev <= sync_2;
    end
  end

  assign rise = sync_2 & ~sync_prev;
  assign fall = ~sync_2 & sync_prev;

  // High time in ticks, saturating so a stuck line never lands in range
  always_ff @(posedge clk) begin
    if (rst) begin
      high_cnt <= '0;
    end else if (rise) begin
      high_cnt <= tick ? WIDTH_BITS'(1) : '0;
    end else if (sync_2 && tick && high_cnt != '1) begin
      high_cnt <= high_cnt + 1'b1;
    end
  end

  assign in_range = (high_cnt >= WIDTH_BITS'(PULSE_MIN_US)) &&
                    (high_cnt <= WIDTH_BITS'(PULSE_MAX_US));

  // Accept on the falling edge, age out otherwise
  always_ff @(posedge clk) begin
    if (rst) begin
      chan    <= '0;
      age_cnt <= '0;
    end else if (fall && in_range) begin
      chan.width_us <= high_cnt;
      chan.live     <= 1'b1;
      age_cnt       <= '0;
    end else if (chan.live && tick) begin
      if (age_cnt == LOSS_BITS'(LOSS_US - 1)) begin
        // Receiver or channel gone quiet
        chan.live <= 1'b0;
        age_cnt   <= '0;
      end else begin
        age_cnt <= age_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== us_tick_gen.sv ====
/*
  One-cycle tick every TICK_DIV clocks, first one TICK_DIV cycles after reset.
*/
`timescale 1ns/1ps

module us_tick_gen import avionics_pkg::*; (
  input  logic clk,
  input  logic rst,
  output logic tick
);

  logic [TICK_BITS-1:0] div_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= TICK_BITS'(TICK_DIV - 1);
      tick    <= 1'b0;
    end else if (div_cnt == '0) begin
      // Reload and fire
      div_cnt <= TICK_BITS'(TICK_DIV - 1);
      tick    <= 1'b1;
    end else begin
      div_cnt <= div_cnt - 1'b1;
      tick    <= 1'b0;
    end
  end

endmodule

// ==== avionics_pkg.sv ====
/*
  Shared constants and types for the flight-board subsystem.
  Timing values are in microsecond ticks and assume a 10 MHz clock.
*/
package avionics_pkg;

  // Channel count, shared by radio inputs and ESC outputs
  localparam int N_CH = 8;

  // Tick generator
  localparam int TICK_DIV  = 10;
  localparam int TICK_BITS = $clog2(TICK_DIV);

  // Pulse measurement
  localparam int WIDTH_BITS   = 12;
  localparam int PULSE_MIN_US = 800;
  localparam int PULSE_MAX_US = 2200;

  // Receiver loss timeout
  localparam int LOSS_US   = 30000;
  localparam int LOSS_BITS = $clog2(LOSS_US + 1);

  // ESC output range and frame
  localparam int ESC_MIN_US   = 1000;
  localparam int ESC_MAX_US   = 2000;
  localparam int ESC_FRAME_US = 2500;
  localparam int FRAME_BITS   = $clog2(ESC_FRAME_US);

  // Arm switch
  localparam int ARM_CH        = 4;
  localparam int ARM_THRESH_US = 1500;

  typedef enum logic [1:0] {
    BOARD_IDLE     = 2'd0,
    BOARD_STARTUP  = 2'd1,
    BOARD_RUNNING  = 2'd2,
    BOARD_SHUTDOWN = 2'd3
  } board_state_t;

  // One measured radio channel
  typedef struct packed {
    logic [WIDTH_BITS-1:0] width_us;
    logic                  live;
  } rc_chan_t;

endpackage
